// File: e8.f
+incdir+verification
common/e8_state_pkg.sv
common/e8_io_pkg.sv
e8_ctrl/e8_next_state.sv
e8_ctrl/e8_action_decode.sv
e8_ctrl/e8_controller.sv
design/e8_top.sv
verification/e8_checker.sv
verification/e8_props.sv
verification/tb_e8.sv

// File: Bender.yml
package:
  name: e8

sources:
  - common/e8_state_pkg.sv
  - common/e8_io_pkg.sv
  - e8_ctrl/e8_next_state.sv
  - e8_ctrl/e8_action_decode.sv
  - e8_ctrl/e8_controller.sv
  - design/e8_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/e8_checker.sv
      - verification/e8_props.sv
      - verification/tb_e8.sv

// File: verification/tb_e8.sv
`timescale 1ns/1ps

module tb_e8;

	logic rst;
	logic clk;
	logic in_valid;
	logic [e8_io_pkg::cond_w-1:0] cond;
	logic out_valid;
	logic [e8_io_pkg::cmd_w-1:0] cmd;
	logic [e8_state_pkg::state_w-1:0] state;
	int checks;
	int errors;
	int local_fails;
	int tests_run;
	int tests_failed;
	int fails_at_start;

	e8_top uut (
		.rst       (rst),
		.clk       (clk),
		.in_valid  (in_valid),
		.cond      (cond),
		.out_valid (out_valid),
		.cmd       (cmd),
		.state     (state)
	);

	e8_checker u_checker (
		.rst       (rst),
		.clk       (clk),
		.in_valid  (in_valid),
		.cond      (cond),
		.out_valid (out_valid),
		.cmd       (cmd),
		.state     (state),
		.checks    (checks),
		.errors    (errors)
	);

	always #5 rst = ~rst;

	function automatic logic [e8_io_pkg::cond_w-1:0] random_word();
		logic [31:0] r;
		r = $urandom;
		return r[e8_io_pkg::cond_w-1:0];
	endfunction

	// Failures from the checker, the testbench and the bound assertions.
	function automatic int total_fails();
		return errors + local_fails + uut.u_controller.u_props.failures;
	endfunction

	task automatic drive_strobe(input logic [e8_io_pkg::cond_w-1:0] word);
		@(posedge rst);
		in_valid <= 1'b1;
		cond <= word;
	endtask

	task automatic drive_idle(input int cycles);
		repeat (cycles)
		begin
			@(posedge rst);
			in_valid <= 1'b0;
			cond <= random_word(); // Ignored while idle.
		end
	endtask

	task automatic await_result();
		int n;
		n = 0;
		@(negedge rst);
		while (!out_valid && n < 8)
		begin
			@(negedge rst);
			n++;
		end
		if (!out_valid)
		begin
			local_fails++;
			$display("no result within 8 cycles of a strobe");
		end
	endtask

	task automatic await_quiet();
		int n;
		n = 0;
		@(negedge rst);
		while (out_valid && n < 8)
		begin
			@(negedge rst);
			n++;
		end
		if (out_valid)
		begin
			local_fails++;
			$display("out_valid still high 8 cycles after the last strobe");
		end
	endtask

	task automatic step(input logic [e8_io_pkg::cond_w-1:0] word);
		drive_strobe(word);
		drive_idle(1);
		await_result();
	endtask

	task automatic pulse_reset();
		@(posedge rst);
		clk <= 1'b0;
		in_valid <= 1'b0;
		repeat (2) @(posedge rst);
		clk <= 1'b1;
	endtask

	task automatic expect_state(input logic [e8_state_pkg::state_w-1:0] code);
		if (state !== code)
		begin
			local_fails++;
			$display("mismatch state: got %h expected %h", state, code);
		end
	endtask

	task automatic expect_reset_outputs();
		expect_state(e8_state_pkg::st_reset);
		if (cmd !== '0)
		begin
			local_fails++;
			$display("mismatch cmd: got %h expected %h", cmd, 20'h0);
		end
		if (out_valid !== 1'b0)
		begin
			local_fails++;
			$display("mismatch out_valid: got %h expected %h", out_valid, 1'b0);
		end
	endtask

	// Lets the checker compare the last result first.
	task automatic finish_test(input string name);
		int now_fails;
		@(negedge rst);
		now_fails = total_fails();
		tests_run++;
		if (now_fails != fails_at_start)
		begin
			tests_failed++;
			$display("%s: failed, %0d errors", name, now_fails - fails_at_start);
		end
		else
			$display("%s: ok", name);
		fails_at_start = now_fails;
	endtask

	initial
	begin
		int seed;
		logic [e8_io_pkg::cond_w-1:0] row;
		rst = 1'b0;
		clk = 1'b0;
		in_valid = 1'b0;
		cond = '0;
		local_fails = 0;
		tests_run = 0;
		tests_failed = 0;
		fails_at_start = 0;
		seed = 32'hb92a_452d;
		void'($urandom(seed));

		repeat (2) @(posedge rst);
		clk <= 1'b1;
		@(negedge rst);
		expect_reset_outputs();
		finish_test("reset state");

		repeat (2000)
			step(random_word());
		finish_test("random strobes");

		repeat (300)
		begin
			drive_strobe(random_word());
			drive_idle($urandom_range(3, 0));
		end
		drive_idle(1);
		await_quiet();
		finish_test("idle gaps");

		repeat (200)
			drive_strobe(random_word());
		drive_idle(1);
		await_quiet();
		finish_test("back to back");

		// Loop s1, s9 and back through each plain s9 command row.
		pulse_reset();
		for (int v = 0; v < 12; v++)
		begin
			step(13'h0400); // x11 enters s9.
			expect_state(e8_state_pkg::st_s9);
			step(13'h0200); // x10 without x2 holds.
			expect_state(e8_state_pkg::st_s9);
			case (v % 3)
				0: row = 13'h0001; // x1 to s5.
				1: row = 13'h0002; // x2 to s11.
				default: row = 13'h0000; // To s12.
			endcase
			step(row);
			if (v % 3 == 0)
				step(13'h0000); // s5 to s12.
			step((v % 3 == 1) ? 13'h0004 : 13'h0404);
			expect_state(e8_state_pkg::st_s1);
		end
		finish_test("s9 revisits");

		repeat (60)
		begin
			@(posedge rst);
			in_valid <= $urandom_range(1, 0);
			cond <= random_word();
		end
		pulse_reset();
		@(negedge rst);
		expect_reset_outputs();
		repeat (100)
			drive_strobe(random_word());
		drive_idle(1);
		await_quiet();
		finish_test("mid-run reset");

		$display("tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, total_fails());
		if (tests_failed == 0 && total_fails() == 0 && checks > 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: verification/e8_props.sv
`timescale 1ns/1ps

// Clock is rst, active-low reset is clk.
module e8_props (
	input logic                             rst,
	input logic                             clk,
	input logic                             in_valid,
	input logic                             out_valid,
	input logic [e8_io_pkg::cmd_w-1:0]      cmd,
	input logic [e8_state_pkg::state_w-1:0] state
);

	int failures;

	initial
		failures = 0;

	assert property (@(posedge rst) !clk |=> !out_valid)
		else
		begin
			failures++;
			$error("out_valid high after a reset edge");
		end

	assert property (@(posedge rst) disable iff (!clk)
		$past(clk) |-> out_valid == $past(in_valid))
		else
		begin
			failures++;
			$error("out_valid does not follow in_valid");
		end

	assert property (@(posedge rst) disable iff (!clk) !out_valid |-> cmd == '0)
		else
		begin
			failures++;
			$error("cmd not zero without out_valid");
		end

	assert property (@(posedge rst) disable iff (!clk)
		state != '0 && state <= e8_state_pkg::num_states)
		else
		begin
			failures++;
			$error("illegal state code");
		end

endmodule

bind e8_controller e8_props u_props (
	.rst       (rst),
	.clk       (clk),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.cmd       (cmd),
	.state     (state)
);

// File: verification/e8_ref_model.svh
`ifndef E8_REF_MODEL_SVH
`define E8_REF_MODEL_SVH

// States are numbered as in the table; state sn has code n.
// A negative result marks a move that issues no commands.
function automatic int model_next(
	input  int                            n,
	input  logic [e8_io_pkg::cond_w-1:0] c,
	output bit                            issues
);
	logic [13:1] x;
	int t;
	x = c; // x[n] is input xn.
	case (n)
		1:
			if (x[10] && x[11] && x[12] && x[13])
				t = x[7] ? 2 : (x[1] ? (x[5] ? 3 : 4) : 5);
			else if (x[10] && x[11] && x[12])
				t = x[5] ? 6 : 4;
			else if (x[10] && x[11])
				t = x[1] ? (x[5] ? (x[13] ? 3 : 7) : 4) : 5;
			else if (x[10])
				t = 8;
			else if (x[11])
				t = x[12] ? (x[8] ? 2 : (x[5] ? 3 : 4)) : 9;
			else if (x[12])
				t = x[1] ? ((x[3] && x[6]) ? 10 : 4) : 5;
			else if (x[13])
				t = x[1] ? 5 : (x[2] ? 11 : 12);
			else
				t = 7;
		2: t = (x[7] && (x[10] ? !x[11] : !x[12])) ? -1 : 13;
		3: t = x[11] ? 13 : (x[5] ? 14 : (x[1] ? 12 : 11));
		4:
			if (x[10] && x[11])
				t = !x[4] ? -4 : ((!x[13] && x[3]) ? (x[12] ? 15 : 9) : 11);
			else if (x[10])
				t = -1;
			else if (x[11])
				t = !x[12] ? -1 : (x[4] ? 11 : -4);
			else
				t = !x[12] ? -1 : (x[4] ? (x[3] ? 16 : 11) : -4);
		5: t = (x[2] && !x[12]) ? 11 : 12;
		6: t = x[10] ? (x[2] ? 14 : -6) : (x[3] ? -1 : 4);
		7: t = !x[10] ? 18 : (!x[2] ? -7 : (x[6] ? 17 : 18));
		8: t = x[11] ? -1 : (x[1] ? 10 : 16);
		9: t = x[10] ? (!x[2] ? -9 : (x[6] ? 17 : 18)) : (x[1] ? 5 : (x[2] ? 11 : 12));
		10: t = x[10] ? 16 : (x[4] ? 2 : -10);
		11:
			if (x[10] && x[11])
				t = !x[5] ? 4 : (x[13] ? 3 : (x[12] ? 6 : 7));
			else if (x[10])
				t = (x[8] && !x[1]) ? 4 : 3;
			else if (x[12])
				t = x[11] ? (x[5] ? 3 : 4) : ((x[3] && x[6]) ? 10 : 4);
			else
				t = x[1] ? 6 : (x[3] ? -1 : 4);
		12:
			if (x[10])
				t = !x[11] ? 3 : (!x[5] ? 4 : (x[13] ? 3 : 7));
			else if (x[11] || (!x[12] && x[13]))
				t = x[1] ? 6 : (x[3] ? -1 : 4);
			else if (x[12])
				t = (x[3] && x[6]) ? 10 : 4;
			else
				t = 17;
		13: t = (x[10] ? x[11] : x[12]) ? (x[4] ? 8 : -13) : -1;
		14: t = (x[11] || x[9]) ? 2 : (x[7] ? -1 : 13);
		15: t = x[2] ? 14 : -15;
		16: t = x[10] ? (x[1] ? 12 : 11) : 2;
		17:
			if (x[10])
				t = x[4] ? 2 : -17;
			else if (x[5])
				t = x[6] ? 2 : (x[7] ? -1 : 13);
			else
				t = x[4] ? 12 : 17; // Re-issues on the self-loop.
		18: t = x[10] ? 2 : (x[4] ? 12 : 17);
		default: t = -1;
	endcase
	issues = (t > 0);
	return (t > 0) ? t : -t;
endfunction

// Command word of an entered state, bit n-1 is yn.
function automatic logic [e8_io_pkg::cmd_w-1:0] expected_pattern(input int n);
	case (n)
		2: return 20'h08000; // y16.
		3: return 20'h40000; // y19.
		4: return 20'h00181; // y1 y8 y9.
		5: return 20'h00007; // y1 y2 y3.
		6: return 20'h00803; // y1 y2 y12.
		7: return 20'h00a02; // y2 y10 y12.
		8: return 20'h20000; // y18.
		9: return 20'h00e00; // y10 y11 y12.
		10: return 20'h04140; // y7 y9 y15.
		11: return 20'h00010; // y5.
		12: return 20'h00008; // y4.
		13: return 20'h10180; // y8 y9 y17.
		14: return 20'h00020; // y6.
		15: return 20'h00c01; // y1 y11 y12.
		16: return 20'h80000; // y20.
		17: return 20'h06101; // y1 y9 y14 y15.
		18: return 20'h01000; // y13.
		default: return '0;
	endcase
endfunction

`endif

// File: verification/e8_checker.sv
`timescale 1ns/1ps

module e8_checker (
	input  logic                             rst,
	input  logic                             clk,
	input  logic                             in_valid,
	input  logic [e8_io_pkg::cond_w-1:0]     cond,
	input  logic                             out_valid,
	input  logic [e8_io_pkg::cmd_w-1:0]      cmd,
	input  logic [e8_state_pkg::state_w-1:0] state,
	output int                               checks,
	output int                               errors
);

	`include "e8_ref_model.svh"

	int model_state;
	bit model_issues;
	bit in_reset;
	logic exp_valid;
	logic [e8_io_pkg::cmd_w-1:0] exp_cmd;
	logic [e8_state_pkg::state_w-1:0] exp_state;

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic compare_outputs();
		compare_value("state", state, exp_state);
		compare_value("cmd", cmd, exp_cmd);
		compare_value("out_valid", out_valid, exp_valid);
	endtask

	initial
	begin
		checks = 0;
		errors = 0;
		in_reset = 1'b0;
		model_state = 1;
		exp_valid = 1'b0;
		exp_cmd = '0;
		exp_state = e8_state_pkg::st_reset;
	end

	// Outputs seen at an edge hold the result of the edge before.
	always @(posedge rst)
	begin
		if (!clk)
		begin
			if (in_reset)
				compare_outputs(); // Second reset edge onward.
			in_reset = 1'b1;
			model_state = 1;
			exp_valid = 1'b0;
			exp_cmd = '0;
			exp_state = e8_state_pkg::st_reset;
		end
		else
		begin
			in_reset = 1'b0;
			compare_outputs();
			exp_valid = in_valid;
			exp_cmd = '0;
			if (in_valid)
			begin
				model_state = model_next(model_state, cond, model_issues);
				if (model_issues)
					exp_cmd = expected_pattern(model_state);
			end
			exp_state = model_state[e8_state_pkg::state_w-1:0];
		end
	end

endmodule

// File: design/e8_top.sv
`timescale 1ns/1ps

module e8_top (
	input  logic                             rst,
	input  logic                             clk,
	input  logic                             in_valid,
	input  logic [e8_io_pkg::cond_w-1:0]     cond,
	output logic                             out_valid,
	output logic [e8_io_pkg::cmd_w-1:0]      cmd,
	output logic [e8_state_pkg::state_w-1:0] state
);

	// Clock on rst, active-low reset on clk.
	e8_controller u_controller (
		.rst       (rst),
		.clk       (clk),
		.in_valid  (in_valid),
		.cond      (cond),
		.out_valid (out_valid),
		.cmd       (cmd),
		.state     (state)
	);

endmodule

// File: e8_ctrl/e8_controller.sv
`timescale 1ns/1ps

module e8_controller (
	input  logic                             rst,
	input  logic                             clk,
	input  logic                             in_valid,
	input  logic [e8_io_pkg::cond_w-1:0]     cond,
	output logic                             out_valid,
	output logic [e8_io_pkg::cmd_w-1:0]      cmd,
	output logic [e8_state_pkg::state_w-1:0] state
);

	logic [e8_state_pkg::state_w-1:0] next_state;
	logic                             enter;
	logic [e8_io_pkg::cmd_w-1:0]      pattern;

	e8_next_state u_next_state (
		.cur_state  (state),
		.cond       (cond),
		.next_state (next_state),
		.enter      (enter)
	);

	e8_action_decode u_action_decode (
		.dest_state (next_state),
		.pattern    (pattern)
	);

	// One transition per strobe, result one cycle later.
	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			state <= e8_state_pkg::st_reset;
			cmd <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= in_valid;
			if (in_valid)
				state <= next_state;
			cmd <= (in_valid && enter) ? pattern : '0; // Zero on idle edges.
		end
	end

endmodule

// File: e8_ctrl/e8_action_decode.sv
`timescale 1ns/1ps

module e8_action_decode (
	input  logic [e8_state_pkg::state_w-1:0] dest_state,
	output logic [e8_io_pkg::cmd_w-1:0]      pattern
);

	// One-hot word with command bit idx set.
	function automatic logic [e8_io_pkg::cmd_w-1:0] yb(input int unsigned idx);
		logic [e8_io_pkg::cmd_w-1:0] w;
		w = '0;
		w[idx] = 1'b1;
		return w;
	endfunction

	always_comb
	begin
		case (dest_state)
			e8_state_pkg::st_s2: pattern = yb(e8_io_pkg::cmd_y16);
			e8_state_pkg::st_s3: pattern = yb(e8_io_pkg::cmd_y19);
			e8_state_pkg::st_s4:
				pattern = yb(e8_io_pkg::cmd_y1) | yb(e8_io_pkg::cmd_y8) | yb(e8_io_pkg::cmd_y9);
			e8_state_pkg::st_s5:
				pattern = yb(e8_io_pkg::cmd_y1) | yb(e8_io_pkg::cmd_y2) | yb(e8_io_pkg::cmd_y3);
			e8_state_pkg::st_s6:
				pattern = yb(e8_io_pkg::cmd_y1) | yb(e8_io_pkg::cmd_y2) | yb(e8_io_pkg::cmd_y12);
			e8_state_pkg::st_s7:
				pattern = yb(e8_io_pkg::cmd_y2) | yb(e8_io_pkg::cmd_y10) | yb(e8_io_pkg::cmd_y12);
			e8_state_pkg::st_s8: pattern = yb(e8_io_pkg::cmd_y18);
			e8_state_pkg::st_s9:
				pattern = yb(e8_io_pkg::cmd_y10) | yb(e8_io_pkg::cmd_y11) | yb(e8_io_pkg::cmd_y12);
			e8_state_pkg::st_s10:
				pattern = yb(e8_io_pkg::cmd_y7) | yb(e8_io_pkg::cmd_y9) | yb(e8_io_pkg::cmd_y15);
			e8_state_pkg::st_s11: pattern = yb(e8_io_pkg::cmd_y5);
			e8_state_pkg::st_s12: pattern = yb(e8_io_pkg::cmd_y4);
			e8_state_pkg::st_s13:
				pattern = yb(e8_io_pkg::cmd_y8) | yb(e8_io_pkg::cmd_y9) | yb(e8_io_pkg::cmd_y17);
			e8_state_pkg::st_s14: pattern = yb(e8_io_pkg::cmd_y6);
			e8_state_pkg::st_s15:
				pattern = yb(e8_io_pkg::cmd_y1) | yb(e8_io_pkg::cmd_y11) | yb(e8_io_pkg::cmd_y12);
			e8_state_pkg::st_s16: pattern = yb(e8_io_pkg::cmd_y20);
			e8_state_pkg::st_s17:
				pattern = yb(e8_io_pkg::cmd_y1) | yb(e8_io_pkg::cmd_y9)
					| yb(e8_io_pkg::cmd_y14) | yb(e8_io_pkg::cmd_y15);
			e8_state_pkg::st_s18: pattern = yb(e8_io_pkg::cmd_y13);
			default: pattern = '0; // s1 and illegal codes.
		endcase
	end

endmodule

// File: e8_ctrl/e8_next_state.sv
`timescale 1ns/1ps

module e8_next_state (
	input  logic [e8_state_pkg::state_w-1:0] cur_state,
	input  logic [e8_io_pkg::cond_w-1:0]     cond,
	output logic [e8_state_pkg::state_w-1:0] next_state,
	output logic                             enter
);

	logic x1, x2, x3, x4, x5, x6, x7, x8, x9, x10, x11, x12, x13;
	logic [e8_state_pkg::state_w:0] row; // {enter, next state}.

	// Row that issues the destination's commands.
	function automatic logic [e8_state_pkg::state_w:0] emit(
		input logic [e8_state_pkg::state_w-1:0] dest
	);
		return {1'b1, dest};
	endfunction

	// Row that only changes or holds the state.
	function automatic logic [e8_state_pkg::state_w:0] move(
		input logic [e8_state_pkg::state_w-1:0] dest
	);
		return {1'b0, dest};
	endfunction

	assign x1 = cond[e8_io_pkg::cond_x1];
	assign x2 = cond[e8_io_pkg::cond_x2];
	assign x3 = cond[e8_io_pkg::cond_x3];
	assign x4 = cond[e8_io_pkg::cond_x4];
	assign x5 = cond[e8_io_pkg::cond_x5];
	assign x6 = cond[e8_io_pkg::cond_x6];
	assign x7 = cond[e8_io_pkg::cond_x7];
	assign x8 = cond[e8_io_pkg::cond_x8];
	assign x9 = cond[e8_io_pkg::cond_x9];
	assign x10 = cond[e8_io_pkg::cond_x10];
	assign x11 = cond[e8_io_pkg::cond_x11];
	assign x12 = cond[e8_io_pkg::cond_x12];
	assign x13 = cond[e8_io_pkg::cond_x13];

	// First matching row wins; every chain ends in its last row.
	always_comb
	begin
		case (cur_state)
			e8_state_pkg::st_s1:
				if (x10 && x11 && x12 && x13 && x7) row = emit(e8_state_pkg::st_s2);
				else if (x10 && x11 && x12 && x13 && ~x7 && x1 && x5) row = emit(e8_state_pkg::st_s3);
				else if (x10 && x11 && x12 && x13 && ~x7 && x1 && ~x5) row = emit(e8_state_pkg::st_s4);
				else if (x10 && x11 && x12 && x13 && ~x7 && ~x1) row = emit(e8_state_pkg::st_s5);
				else if (x10 && x11 && x12 && ~x13 && x5) row = emit(e8_state_pkg::st_s6);
				else if (x10 && x11 && x12 && ~x13 && ~x5) row = emit(e8_state_pkg::st_s4);
				else if (x10 && x11 && ~x12 && x1 && x5 && x13) row = emit(e8_state_pkg::st_s3);
				else if (x10 && x11 && ~x12 && x1 && x5 && ~x13) row = emit(e8_state_pkg::st_s7);
				else if (x10 && x11 && ~x12 && x1 && ~x5) row = emit(e8_state_pkg::st_s4);
				else if (x10 && x11 && ~x12 && ~x1) row = emit(e8_state_pkg::st_s5);
				else if (x10 && ~x11) row = emit(e8_state_pkg::st_s8);
				else if (~x10 && x11 && x12 && x8) row = emit(e8_state_pkg::st_s2);
				else if (~x10 && x11 && x12 && ~x8 && x5) row = emit(e8_state_pkg::st_s3);
				else if (~x10 && x11 && x12 && ~x8 && ~x5) row = emit(e8_state_pkg::st_s4);
				else if (~x10 && x11 && ~x12) row = emit(e8_state_pkg::st_s9);
				else if (~x10 && ~x11 && x12 && x1 && x3 && x6) row = emit(e8_state_pkg::st_s10);
				else if (~x10 && ~x11 && x12 && x1 && x3 && ~x6) row = emit(e8_state_pkg::st_s4);
				else if (~x10 && ~x11 && x12 && x1 && ~x3) row = emit(e8_state_pkg::st_s4);
				else if (~x10 && ~x11 && x12 && ~x1) row = emit(e8_state_pkg::st_s5);
				else if (~x10 && ~x11 && ~x12 && x13 && x1) row = emit(e8_state_pkg::st_s5);
				else if (~x10 && ~x11 && ~x12 && x13 && ~x1 && x2) row = emit(e8_state_pkg::st_s11);
				else if (~x10 && ~x11 && ~x12 && x13 && ~x1) row = emit(e8_state_pkg::st_s12);
				else row = emit(e8_state_pkg::st_s7);
			e8_state_pkg::st_s2:
				if (x10 && x11) row = emit(e8_state_pkg::st_s13);
				else if (x10 && ~x11 && x7) row = move(e8_state_pkg::st_s1);
				else if (x10 && ~x11 && ~x7) row = emit(e8_state_pkg::st_s13);
				else if (~x10 && x12) row = emit(e8_state_pkg::st_s13);
				else if (~x10 && ~x12 && x7) row = move(e8_state_pkg::st_s1);
				else row = emit(e8_state_pkg::st_s13);
			e8_state_pkg::st_s3:
				if (x11) row = emit(e8_state_pkg::st_s13);
				else if (~x11 && x5) row = emit(e8_state_pkg::st_s14);
				else if (~x11 && ~x5 && x1) row = emit(e8_state_pkg::st_s12);
				else row = emit(e8_state_pkg::st_s11);
			e8_state_pkg::st_s4:
				if (x10 && x11 && x4 && x12 && x13) row = emit(e8_state_pkg::st_s11);
				else if (x10 && x11 && x4 && x12 && ~x13 && x3) row = emit(e8_state_pkg::st_s15);
				else if (x10 && x11 && x4 && x12 && ~x13 && ~x3) row = emit(e8_state_pkg::st_s11);
				else if (x10 && x11 && x4 && ~x12 && x13) row = emit(e8_state_pkg::st_s11);
				else if (x10 && x11 && x4 && ~x12 && ~x13 && x3) row = emit(e8_state_pkg::st_s9);
				else if (x10 && x11 && x4 && ~x12 && ~x13 && ~x3) row = emit(e8_state_pkg::st_s11);
				else if (x10 && x11 && ~x4) row = move(e8_state_pkg::st_s4);
				else if (x10 && ~x11) row = move(e8_state_pkg::st_s1);
				else if (~x10 && x11 && x12 && x4) row = emit(e8_state_pkg::st_s11);
				else if (~x10 && x11 && x12 && ~x4) row = move(e8_state_pkg::st_s4);
				else if (~x10 && x11 && ~x12) row = move(e8_state_pkg::st_s1);
				else if (~x10 && ~x11 && x12 && x4 && x3) row = emit(e8_state_pkg::st_s16);
				else if (~x10 && ~x11 && x12 && x4 && ~x3) row = emit(e8_state_pkg::st_s11);
				else if (~x10 && ~x11 && x12 && ~x4) row = move(e8_state_pkg::st_s4);
				else row = move(e8_state_pkg::st_s1);
			e8_state_pkg::st_s5:
				if (x2 && x12) row = emit(e8_state_pkg::st_s12);
				else if (x2 && ~x12) row = emit(e8_state_pkg::st_s11);
				else row = emit(e8_state_pkg::st_s12);
			e8_state_pkg::st_s6:
				if (x10 && x2) row = emit(e8_state_pkg::st_s14);
				else if (x10 && ~x2) row = move(e8_state_pkg::st_s6);
				else if (~x10 && x3) row = move(e8_state_pkg::st_s1);
				else row = emit(e8_state_pkg::st_s4);
			e8_state_pkg::st_s7:
				if (x10 && x2 && x6) row = emit(e8_state_pkg::st_s17);
				else if (x10 && x2 && ~x6) row = emit(e8_state_pkg::st_s18);
				else if (x10 && ~x2) row = move(e8_state_pkg::st_s7);
				else row = emit(e8_state_pkg::st_s18);
			e8_state_pkg::st_s8:
				if (x11) row = move(e8_state_pkg::st_s1);
				else if (~x11 && x1) row = emit(e8_state_pkg::st_s10);
				else row = emit(e8_state_pkg::st_s16);
			// Same rows on every visit, no history kept.
			e8_state_pkg::st_s9:
				if (x10 && x2 && x6) row = emit(e8_state_pkg::st_s17);
				else if (x10 && x2 && ~x6) row = emit(e8_state_pkg::st_s18);
				else if (x10 && ~x2) row = move(e8_state_pkg::st_s9);
				else if (~x10 && x1) row = emit(e8_state_pkg::st_s5);
				else if (~x10 && ~x1 && x2) row = emit(e8_state_pkg::st_s11);
				else row = emit(e8_state_pkg::st_s12);
			e8_state_pkg::st_s10:
				if (x10) row = emit(e8_state_pkg::st_s16);
				else if (~x10 && x4) row = emit(e8_state_pkg::st_s2);
				else row = move(e8_state_pkg::st_s10);
			e8_state_pkg::st_s11:
				if (x10 && x11 && x5 && x12 && x13) row = emit(e8_state_pkg::st_s3);
				else if (x10 && x11 && x5 && x12 && ~x13) row = emit(e8_state_pkg::st_s6);
				else if (x10 && x11 && x5 && ~x12 && x13) row = emit(e8_state_pkg::st_s3);
				else if (x10 && x11 && x5 && ~x12 && ~x13) row = emit(e8_state_pkg::st_s7);
				else if (x10 && x11 && ~x5) row = emit(e8_state_pkg::st_s4);
				else if (x10 && ~x11 && x8 && x1) row = emit(e8_state_pkg::st_s3);
				else if (x10 && ~x11 && x8 && ~x1) row = emit(e8_state_pkg::st_s4);
				else if (x10 && ~x11 && ~x8) row = emit(e8_state_pkg::st_s3);
				else if (~x10 && x11 && x12 && x5) row = emit(e8_state_pkg::st_s3);
				else if (~x10 && x11 && x12 && ~x5) row = emit(e8_state_pkg::st_s4);
				else if (~x10 && x11 && ~x12 && x1) row = emit(e8_state_pkg::st_s6);
				else if (~x10 && x11 && ~x12 && ~x1 && x3) row = move(e8_state_pkg::st_s1);
				else if (~x10 && x11 && ~x12 && ~x1 && ~x3) row = emit(e8_state_pkg::st_s4);
				else if (~x10 && ~x11 && x12 && x3 && x6) row = emit(e8_state_pkg::st_s10);
				else if (~x10 && ~x11 && x12 && x3 && ~x6) row = emit(e8_state_pkg::st_s4);
				else if (~x10 && ~x11 && x12 && ~x3) row = emit(e8_state_pkg::st_s4);
				else if (~x10 && ~x11 && ~x12 && x1) row = emit(e8_state_pkg::st_s6);
				else if (~x10 && ~x11 && ~x12 && ~x1 && x3) row = move(e8_state_pkg::st_s1);
				else row = emit(e8_state_pkg::st_s4);
			e8_state_pkg::st_s12:
				if (x10 && x11 && x5 && x13) row = emit(e8_state_pkg::st_s3);
				else if (x10 && x11 && x5 && ~x13) row = emit(e8_state_pkg::st_s7);
				else if (x10 && x11 && ~x5) row = emit(e8_state_pkg::st_s4);
				else if (x10 && ~x11) row = emit(e8_state_pkg::st_s3);
				else if (~x10 && x11 && x1) row = emit(e8_state_pkg::st_s6);
				else if (~x10 && x11 && ~x1 && x3) row = move(e8_state_pkg::st_s1);
				else if (~x10 && x11 && ~x1 && ~x3) row = emit(e8_state_pkg::st_s4);
				else if (~x10 && ~x11 && x12 && x3 && x6) row = emit(e8_state_pkg::st_s10);
				else if (~x10 && ~x11 && x12 && x3 && ~x6) row = emit(e8_state_pkg::st_s4);
				else if (~x10 && ~x11 && x12 && ~x3) row = emit(e8_state_pkg::st_s4);
				else if (~x10 && ~x11 && ~x12 && x13 && x1) row = emit(e8_state_pkg::st_s6);
				else if (~x10 && ~x11 && ~x12 && x13 && ~x1 && x3) row = move(e8_state_pkg::st_s1);
				else if (~x10 && ~x11 && ~x12 && x13 && ~x1) row = emit(e8_state_pkg::st_s4);
				else row = emit(e8_state_pkg::st_s17);
			e8_state_pkg::st_s13:
				if (x10 && x11 && x4) row = emit(e8_state_pkg::st_s8);
				else if (x10 && x11 && ~x4) row = move(e8_state_pkg::st_s13);
				else if (x10 && ~x11) row = move(e8_state_pkg::st_s1);
				else if (~x10 && x12 && x4) row = emit(e8_state_pkg::st_s8);
				else if (~x10 && x12 && ~x4) row = move(e8_state_pkg::st_s13);
				else row = move(e8_state_pkg::st_s1);
			e8_state_pkg::st_s14:
				if (x11) row = emit(e8_state_pkg::st_s2);
				else if (~x11 && x9) row = emit(e8_state_pkg::st_s2);
				else if (~x11 && ~x9 && x7) row = move(e8_state_pkg::st_s1);
				else row = emit(e8_state_pkg::st_s13);
			e8_state_pkg::st_s15:
				if (x2) row = emit(e8_state_pkg::st_s14);
				else row = move(e8_state_pkg::st_s15);
			e8_state_pkg::st_s16:
				if (x10 && x1) row = emit(e8_state_pkg::st_s12);
				else if (x10 && ~x1) row = emit(e8_state_pkg::st_s11);
				else row = emit(e8_state_pkg::st_s2);
			e8_state_pkg::st_s17:
				if (x10 && x4) row = emit(e8_state_pkg::st_s2);
				else if (x10 && ~x4) row = move(e8_state_pkg::st_s17);
				else if (~x10 && x5 && x6) row = emit(e8_state_pkg::st_s2);
				else if (~x10 && x5 && ~x6 && x7) row = move(e8_state_pkg::st_s1);
				else if (~x10 && x5 && ~x6 && ~x7) row = emit(e8_state_pkg::st_s13);
				else if (~x10 && ~x5 && x4) row = emit(e8_state_pkg::st_s12);
				else row = emit(e8_state_pkg::st_s17); // Self-loop that re-issues.
			e8_state_pkg::st_s18:
				if (x10) row = emit(e8_state_pkg::st_s2);
				else if (~x10 && x4) row = emit(e8_state_pkg::st_s12);
				else row = emit(e8_state_pkg::st_s17);
			default:
				row = move(e8_state_pkg::st_s1); // Illegal code recovers.
		endcase
	end

	assign enter = row[e8_state_pkg::state_w];
	assign next_state = row[e8_state_pkg::state_w-1:0];

endmodule

// File: common/e8_io_pkg.sv
package e8_io_pkg;

	localparam int cond_w = 13;
	localparam int cmd_w = 20;

	// Bit n-1 holds input xn.
	localparam int cond_x1 = 0;
	localparam int cond_x2 = 1;
	localparam int cond_x3 = 2;
	localparam int cond_x4 = 3;
	localparam int cond_x5 = 4;
	localparam int cond_x6 = 5;
	localparam int cond_x7 = 6;
	localparam int cond_x8 = 7;
	localparam int cond_x9 = 8;
	localparam int cond_x10 = 9;
	localparam int cond_x11 = 10;
	localparam int cond_x12 = 11;
	localparam int cond_x13 = 12;

	// Bit n-1 holds output yn.
	localparam int cmd_y1 = 0;
	localparam int cmd_y2 = 1;
	localparam int cmd_y3 = 2;
	localparam int cmd_y4 = 3;
	localparam int cmd_y5 = 4;
	localparam int cmd_y6 = 5;
	localparam int cmd_y7 = 6;
	localparam int cmd_y8 = 7;
	localparam int cmd_y9 = 8;
	localparam int cmd_y10 = 9;
	localparam int cmd_y11 = 10;
	localparam int cmd_y12 = 11;
	localparam int cmd_y13 = 12;
	localparam int cmd_y14 = 13;
	localparam int cmd_y15 = 14;
	localparam int cmd_y16 = 15;
	localparam int cmd_y17 = 16;
	localparam int cmd_y18 = 17;
	localparam int cmd_y19 = 18;
	localparam int cmd_y20 = 19;

endpackage

// File: common/e8_state_pkg.sv
package e8_state_pkg;

	localparam int state_w = 5;
	localparam int num_states = 18;

	// Code 0 is illegal.
	localparam logic [state_w-1:0] st_s1 = 5'd1;
	localparam logic [state_w-1:0] st_s2 = 5'd2;
	localparam logic [state_w-1:0] st_s3 = 5'd3;
	localparam logic [state_w-1:0] st_s4 = 5'd4;
	localparam logic [state_w-1:0] st_s5 = 5'd5;
	localparam logic [state_w-1:0] st_s6 = 5'd6;
	localparam logic [state_w-1:0] st_s7 = 5'd7;
	localparam logic [state_w-1:0] st_s8 = 5'd8;
	localparam logic [state_w-1:0] st_s9 = 5'd9;
	localparam logic [state_w-1:0] st_s10 = 5'd10;
	localparam logic [state_w-1:0] st_s11 = 5'd11;
	localparam logic [state_w-1:0] st_s12 = 5'd12;
	localparam logic [state_w-1:0] st_s13 = 5'd13;
	localparam logic [state_w-1:0] st_s14 = 5'd14;
	localparam logic [state_w-1:0] st_s15 = 5'd15;
	localparam logic [state_w-1:0] st_s16 = 5'd16;
	localparam logic [state_w-1:0] st_s17 = 5'd17;
	localparam logic [state_w-1:0] st_s18 = 5'd18;

	localparam logic [state_w-1:0] st_reset = st_s1;

endpackage
